// File: hw/lorenz_ctrl.sv
// ###################################################################
// Control unit of the oscillator. Runs the four-phase command and
// sample handshakes, counts steps and pulses load/step to the datapath.
// ###################################################################

`timescale 1ns/1ps
`default_nettype none

module lorenz_ctrl (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           cmd_req_i,
  input  lorenz_sys_pkg::lorenz_cmd_t    cmd_i,
  output logic                           cmd_ack_o,
  output logic                           smp_req_o,
  input  logic                           smp_ack_i,
  output lorenz_sys_pkg::lorenz_sample_t smp_o,
  output logic                           busy_o,
  output logic                           load_o,
  output logic                           step_o,
  input  lorenz_sys_pkg::lorenz_state_t  state_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_accept,
    st_done,
    st_step,
    st_present,
    st_wait_rel
  } ctrl_state_t;

  ctrl_state_t state_q;

  logic cmd_ack_q;
  logic smp_req_q;
  logic busy_q;
  logic load_q;

  logic [lorenz_sys_pkg::step_cnt_w-1:0] remain_q;
  logic [lorenz_sys_pkg::step_cnt_w-1:0] idx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= st_idle;
      cmd_ack_q <= 1'b0;
      smp_req_q <= 1'b0;
      busy_q    <= 1'b0;
      load_q    <= 1'b0;
      remain_q  <= '0;
      idx_q     <= '0;
    end else begin
      load_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cmd_req_i) begin
            cmd_ack_q <= 1'b1;
            busy_q    <= 1'b1;
            load_q    <= cmd_i.reload;
            remain_q  <= cmd_i.steps;
            idx_q     <= '0;
            state_q   <= st_accept;
          end
        end
        // hold ack until the host releases its request
        st_accept: begin
          if (!cmd_req_i) begin
            cmd_ack_q <= 1'b0;
            state_q   <= st_done;
          end
        end
        // command handshake closed, start stepping or finish
        st_done: begin
          if (remain_q == '0) begin
            busy_q  <= 1'b0;
            state_q <= st_idle;
          end else begin
            state_q <= st_step;
          end
        end
        st_step: begin
          remain_q  <= remain_q - 1'b1;
          idx_q     <= idx_q + 1'b1;
          smp_req_q <= 1'b1;
          state_q   <= st_present;
        end
        st_present: begin
          if (smp_ack_i) begin
            smp_req_q <= 1'b0;
            state_q   <= st_wait_rel;
          end
        end
        // next step only once the ack is back low
        st_wait_rel: begin
          if (!smp_ack_i) begin
            if (remain_q == '0) begin
              busy_q  <= 1'b0;
              state_q <= st_idle;
            end else begin
              state_q <= st_step;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign cmd_ack_o = cmd_ack_q;
  assign smp_req_o = smp_req_q;
  assign busy_o    = busy_q;
  assign load_o    = load_q;
  assign step_o    = (state_q == st_step);

  // datapath regs only move on step_o, so they hold the sample
  // steady for the whole request phase
  assign smp_o.state = state_i;
  assign smp_o.idx   = idx_q;

endmodule

`default_nettype wire

// File: hw/lorenz_datapath.sv
// ###################################################################
// Forward Euler step of the Lorenz system, one step per cycle.
// load_i restores the initial point, step_i advances the state.
// ###################################################################

`timescale 1ns/1ps
`default_nettype none

module lorenz_datapath (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          load_i,
  input  logic                          step_i,
  output lorenz_sys_pkg::lorenz_state_t state_o
);

  lorenz_sys_pkg::lorenz_state_t state_q;
  lorenz_sys_pkg::lorenz_state_t state_d;
  lorenz_sys_pkg::lorenz_state_t init_state;

  lorenz_fixed_pkg::fx_t x;
  lorenz_fixed_pkg::fx_t y;
  lorenz_fixed_pkg::fx_t z;

  // x path
  lorenz_fixed_pkg::fx_t yx_diff;
  lorenz_fixed_pkg::fx_t x_sig;
  lorenz_fixed_pkg::fx_t x_inc;

  // y path
  lorenz_fixed_pkg::fx_t rho_diff;
  lorenz_fixed_pkg::fx_t x_rho;
  lorenz_fixed_pkg::fx_t y_diff;
  lorenz_fixed_pkg::fx_t y_inc;

  // z path
  lorenz_fixed_pkg::fx_t xy_prod;
  lorenz_fixed_pkg::fx_t bz_prod;
  lorenz_fixed_pkg::fx_t z_diff;
  lorenz_fixed_pkg::fx_t z_inc;

  assign x = state_q.x;
  assign y = state_q.y;
  assign z = state_q.z;

  assign init_state = '{
    x: lorenz_sys_pkg::x0_c,
    y: lorenz_sys_pkg::y0_c,
    z: lorenz_sys_pkg::z0_c
  };

  // dx = h * sigma * (y - x), sigma applied before h
  always_comb begin
    yx_diff = y - x;
    x_sig   = lorenz_fixed_pkg::fx_mul(yx_diff, lorenz_sys_pkg::sigma_c);
    x_inc   = lorenz_fixed_pkg::fx_mul(x_sig, lorenz_sys_pkg::h_c);
  end

  // dy = h * (x * (rho - z) - y)
  always_comb begin
    rho_diff = lorenz_sys_pkg::rho_c - z;
    x_rho    = lorenz_fixed_pkg::fx_mul(rho_diff, x);
    y_diff   = x_rho - y;
    y_inc    = lorenz_fixed_pkg::fx_mul(y_diff, lorenz_sys_pkg::h_c);
  end

  // dz = h * (x * y - beta * z)
  always_comb begin
    xy_prod = lorenz_fixed_pkg::fx_mul(y, x);
    bz_prod = lorenz_fixed_pkg::fx_mul(lorenz_sys_pkg::beta_c, z);
    z_diff  = xy_prod - bz_prod;
    z_inc   = lorenz_fixed_pkg::fx_mul(z_diff, lorenz_sys_pkg::h_c);
  end

  // sums wrap on overflow
  always_comb begin
    state_d.x = x + x_inc;
    state_d.y = y + y_inc;
    state_d.z = z + z_inc;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || load_i) begin
      state_q <= init_state;
    end else if (step_i) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// File: hw/lorenz_fixed_pkg.sv
// ###################################################################
// Fixed-point format of the oscillator, signed A(11,20) in 32 bits.
// Shared by the datapath and the testbench reference model.
// ###################################################################

`default_nettype none

package lorenz_fixed_pkg;

  // word layout: 1 sign, 11 integer, 20 fraction bits
  localparam int fx_width = 32;
  localparam int fx_frac  = 20;

  typedef logic signed [fx_width-1:0] fx_t;

  // full-width signed product, then keep the middle word
  // low fraction bits are dropped (rounds toward minus infinity),
  // high bits wrap
  function automatic fx_t fx_mul(input fx_t a, input fx_t b);
    logic signed [2*fx_width-1:0] prod;
    prod = a * b;
    return prod[fx_width+fx_frac-1:fx_frac];
  endfunction

endpackage

`default_nettype wire

// File: hw/lorenz_sys_pkg.sv
// ###################################################################
// Lorenz system constants and the structs that carry state, commands
// and samples between the host ports, the control unit and datapath.
// ###################################################################

`default_nettype none

package lorenz_sys_pkg;

  // classic chaotic parameter set
  localparam lorenz_fixed_pkg::fx_t sigma_c = 32'sd10 <<< lorenz_fixed_pkg::fx_frac;
  localparam lorenz_fixed_pkg::fx_t rho_c   = 32'sd28 <<< lorenz_fixed_pkg::fx_frac;
  // 8/3 * 2^20 = 2796202.67, truncated
  localparam lorenz_fixed_pkg::fx_t beta_c  = 32'sd2796202;
  // 0.01 * 2^20 = 10485.76, truncated
  localparam lorenz_fixed_pkg::fx_t h_c     = 32'sd10485;

  // initial point (1, 1, 1)
  localparam lorenz_fixed_pkg::fx_t x0_c = 32'sd1 <<< lorenz_fixed_pkg::fx_frac;
  localparam lorenz_fixed_pkg::fx_t y0_c = 32'sd1 <<< lorenz_fixed_pkg::fx_frac;
  localparam lorenz_fixed_pkg::fx_t z0_c = 32'sd1 <<< lorenz_fixed_pkg::fx_frac;

  localparam int step_cnt_w = 16;

  typedef struct packed {
    lorenz_fixed_pkg::fx_t x;
    lorenz_fixed_pkg::fx_t y;
    lorenz_fixed_pkg::fx_t z;
  } lorenz_state_t;

  // reload set restarts from (x0, y0, z0), else continue
  typedef struct packed {
    logic                  reload;
    logic [step_cnt_w-1:0] steps;
  } lorenz_cmd_t;

  // idx counts 1..steps within one command
  typedef struct packed {
    lorenz_state_t         state;
    logic [step_cnt_w-1:0] idx;
  } lorenz_sample_t;

endpackage

`default_nettype wire

// File: hw/lorenz_top.sv
// ###################################################################
// Top level of the Lorenz oscillator. Host sends step commands on a
// req/ack channel and takes x, y, z samples on a second req/ack one.
// ###################################################################

`timescale 1ns/1ps
`default_nettype none

module lorenz_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           cmd_req_i,
  input  lorenz_sys_pkg::lorenz_cmd_t    cmd_i,
  output logic                           cmd_ack_o,
  output logic                           smp_req_o,
  output lorenz_sys_pkg::lorenz_sample_t smp_o,
  input  logic                           smp_ack_i,
  output logic                           busy_o
);

  logic                          load;
  logic                          step;
  lorenz_sys_pkg::lorenz_state_t state;

  // handshakes and step sequencing
  lorenz_ctrl i_lorenz_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_req_i (cmd_req_i),
    .cmd_i     (cmd_i),
    .cmd_ack_o (cmd_ack_o),
    .smp_req_o (smp_req_o),
    .smp_ack_i (smp_ack_i),
    .smp_o     (smp_o),
    .busy_o    (busy_o),
    .load_o    (load),
    .step_o    (step),
    .state_i   (state)
  );

  // euler arithmetic and state regs
  lorenz_datapath i_lorenz_datapath (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (load),
    .step_i  (step),
    .state_o (state)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the Lorenz oscillator testbench with Verilator and run it.
# Exit status is non-zero unless the log reports a pass.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module lorenz_tb \
  -f sim.f \
  -o lorenz_sim

./obj_dir/lorenz_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sim.f
hw/lorenz_fixed_pkg.sv
hw/lorenz_sys_pkg.sv
hw/lorenz_ctrl.sv
hw/lorenz_datapath.sv
hw/lorenz_top.sv
verif/lorenz_assertions.sv
verif/lorenz_tb.sv

// File: verif/lorenz_assertions.sv
// ###################################################################
// Handshake protocol checks for the oscillator control unit.
// Bound into every lorenz_ctrl instance from the bottom of this file.
// ###################################################################

`timescale 1ns/1ps
`default_nettype none

module lorenz_assertions (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           cmd_req_i,
  input logic                           cmd_ack_i,
  input logic                           smp_req_i,
  input logic                           smp_ack_i,
  input logic                           step_i,
  input lorenz_sys_pkg::lorenz_sample_t smp_i
);

  // failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // sample must not move while the host has not taken it
  smp_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (smp_req_i && !smp_ack_i) |=> $stable(smp_i))
    else begin
      fail_cnt++;
      $error("sample changed while its request was pending");
    end

  // a new request only after the previous ack is released,
  // ack as seen on the edge that raised the request
  smp_req_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(smp_req_i) |-> !$past(smp_ack_i))
    else begin
      fail_cnt++;
      $error("sample request rose while ack was still high");
    end

  // ack answers the request seen one edge earlier
  cmd_ack_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cmd_ack_i) |-> $past(cmd_req_i))
    else begin
      fail_cnt++;
      $error("command ack rose without a command request");
    end

  // state may only advance once the sample is gone
  step_vs_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    step_i |-> !smp_req_i)
    else begin
      fail_cnt++;
      $error("step pulse while a sample request was pending");
    end

endmodule

bind lorenz_ctrl lorenz_assertions i_lorenz_assertions (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .cmd_req_i (cmd_req_i),
  .cmd_ack_i (cmd_ack_o),
  .smp_req_i (smp_req_o),
  .smp_ack_i (smp_ack_i),
  .step_i    (step_o),
  .smp_i     (smp_o)
);

`default_nettype wire

// File: verif/lorenz_tb.sv
// ###################################################################
// Directed testbench for the Lorenz oscillator top level. Acts as the
// host on both handshakes and checks every sample against a model.
// ###################################################################

`timescale 1ns/1ps
`default_nettype none

module lorenz_tb;

  // 8 + 6 + 20 + 0 + 10 + 5 steps over all tests
  localparam int total_steps = 49;
  localparam int cycle_limit = total_steps * 16 + 200;

  logic                           clk;
  logic                           reset;
  logic                           cmd_req;
  lorenz_sys_pkg::lorenz_cmd_t    cmd;
  logic                           cmd_ack;
  logic                           smp_req;
  lorenz_sys_pkg::lorenz_sample_t smp;
  logic                           smp_ack;
  logic                           busy;

  int          err_cnt;
  int          cycle_cnt;
  logic [31:0] rng;

  lorenz_fixed_pkg::fx_t model_x;
  lorenz_fixed_pkg::fx_t model_y;
  lorenz_fixed_pkg::fx_t model_z;

  lorenz_top i_lorenz_top (
    .clk_i     (clk),
    .reset_i   (reset),
    .cmd_req_i (cmd_req),
    .cmd_i     (cmd),
    .cmd_ack_o (cmd_ack),
    .smp_req_o (smp_req),
    .smp_o     (smp),
    .smp_ack_i (smp_ack),
    .busy_o    (busy)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic model_reset();
    model_x = lorenz_sys_pkg::x0_c;
    model_y = lorenz_sys_pkg::y0_c;
    model_z = lorenz_sys_pkg::z0_c;
  endtask

  // one forward Euler step of the Lorenz equations
  task automatic model_step();
    lorenz_fixed_pkg::fx_t dx;
    lorenz_fixed_pkg::fx_t dy;
    lorenz_fixed_pkg::fx_t dz;
    dx = lorenz_fixed_pkg::fx_mul(lorenz_fixed_pkg::fx_mul(model_y - model_x,
      lorenz_sys_pkg::sigma_c), lorenz_sys_pkg::h_c);
    dy = lorenz_fixed_pkg::fx_mul(lorenz_fixed_pkg::fx_mul(
      lorenz_sys_pkg::rho_c - model_z, model_x) - model_y, lorenz_sys_pkg::h_c);
    dz = lorenz_fixed_pkg::fx_mul(lorenz_fixed_pkg::fx_mul(model_y, model_x)
      - lorenz_fixed_pkg::fx_mul(lorenz_sys_pkg::beta_c, model_z), lorenz_sys_pkg::h_c);
    model_x = model_x + dx;
    model_y = model_y + dy;
    model_z = model_z + dz;
  endtask

  // wait for the ack to a raised request, then close the handshake
  task automatic finish_cmd();
    while (!cmd_ack) @(negedge clk);
    check_value("busy_o", 32'd1, 32'(busy));
    cmd_req = 1'b0;
    while (cmd_ack) @(negedge clk);
  endtask

  task automatic send_cmd(input bit reload, input int steps);
    @(negedge clk);
    cmd.reload = reload;
    cmd.steps  = 16'(steps);
    cmd_req    = 1'b1;
    finish_cmd();
  endtask

  task automatic take_sample(input int exp_idx, input bit random_delay);
    logic [2:0] delay;
    delay = 3'd0;
    while (!smp_req) @(negedge clk);
    if (random_delay) begin
      rng   = lcg_next(rng);
      delay = rng[18:16];
    end
    repeat (delay) @(negedge clk);
    model_step();
    check_value("smp_o.state.x", model_x, smp.state.x);
    check_value("smp_o.state.y", model_y, smp.state.y);
    check_value("smp_o.state.z", model_z, smp.state.z);
    check_value("smp_o.idx", exp_idx, 32'(smp.idx));
    smp_ack = 1'b1;
    while (smp_req) @(negedge clk);
    smp_ack = 1'b0;
  endtask

  task automatic run_steps(input bit reload, input int steps, input bit random_delay);
    if (reload) begin
      model_reset();
    end
    send_cmd(reload, steps);
    for (int i = 1; i <= steps; i++) begin
      take_sample(i, random_delay);
    end
    while (busy) @(negedge clk);
    check_value("smp_req_o", 32'd0, 32'(smp_req));
  endtask

  task automatic test_reset_values();
    @(negedge clk);
    check_value("cmd_ack_o", 32'd0, 32'(cmd_ack));
    check_value("smp_req_o", 32'd0, 32'(smp_req));
    check_value("busy_o", 32'd0, 32'(busy));
  endtask

  task automatic test_zero_steps();
    bit saw_req;
    saw_req = 1'b0;
    send_cmd(1'b0, 0);
    repeat (20) begin
      @(negedge clk);
      if (smp_req) saw_req = 1'b1;
    end
    check_value("smp_req_o", 32'd0, 32'(saw_req));
    check_value("busy_o", 32'd0, 32'(busy));
  endtask

  // second command raised mid-run must wait for busy to fall
  task automatic test_late_command();
    bit early_ack;
    early_ack = 1'b0;
    model_reset();
    send_cmd(1'b1, 10);
    @(negedge clk);
    cmd.reload = 1'b1;
    cmd.steps  = 16'd5;
    cmd_req    = 1'b1;
    fork
      begin
        for (int i = 1; i <= 10; i++) begin
          take_sample(i, 1'b0);
        end
        while (busy) @(negedge clk);
      end
      begin
        while (busy) begin
          if (cmd_ack) early_ack = 1'b1;
          @(negedge clk);
        end
      end
    join
    check_value("cmd_ack_o", 32'd0, 32'(early_ack));
    model_reset();
    finish_cmd();
    for (int i = 1; i <= 5; i++) begin
      take_sample(i, 1'b0);
    end
    while (busy) @(negedge clk);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Error: timeout, the tests did not finish within %0d cycles", cycle_limit);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int assert_fails;
    clk     = 1'b0;
    reset   = 1'b1;
    cmd_req = 1'b0;
    cmd     = '0;
    smp_ack = 1'b0;
    err_cnt = 0;
    rng     = 32'h4749b9a2;
    model_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_values();
    run_steps(1'b1, 8, 1'b0);
    run_steps(1'b0, 6, 1'b0);
    run_steps(1'b0, 20, 1'b1);
    test_zero_steps();
    test_late_command();

    assert_fails = i_lorenz_top.i_lorenz_ctrl.i_lorenz_assertions.fail_cnt;
    $display("check errors: %0d, assertion failures: %0d", err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
